//--- vlog.f
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/rename_if.sv
verilog/rename_state.sv
verilog/rename.sv
verilog/instr_fifo.sv
verilog/dispatch.sv
verilog/dispatch_top.sv
verification/dispatch_assertions.sv
verification/dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f --top-module dispatch_tb &&
./obj_dir/Vdispatch_tb | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/dispatch_tb.sv
// dispatch stage testbench: micro-op stimulus and back-pressure control
// rename reference model and a compare process checking every cycle

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module dispatch_tb import dispatch_pkg::*; ();

	logic          clk;
	logic          reset;
	logic          uop_push;
	micro_op_t     uop_in;
	logic          uop_full;
	logic          alu_push, bru_push, lsu_push, csr_push;
	logic          alu_full, bru_full, lsu_full, csr_full;
	issue_info_t   alu_info, bru_info, lsu_info, csr_info;
	logic          reorder_push;
	logic          reorder_full;
	reorder_info_t reorder_info;
	logic          lsu_busy;
	logic          commit_valid;
	phys_reg_t     commit_name;

	logic [`RB-1:0] act_m [`ARCH_REGS];
	logic [`RP-1:0] used_m [`ARCH_REGS];
	micro_op_t      model_q [$];
	logic [63:0]    pc_ctr;
	int             errors;

	dispatch_top u_dut (.CLK(clk), .*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_error(input string why);
		errors++;
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_issue(input string name, input issue_info_t got, input issue_info_t exp);
		if (got !== exp)
			stop_with_error($sformatf("FAIL t=%0t %s got %h exp %h", $time, name, got, exp));
	endtask

	task automatic check_reorder(input string name, input reorder_info_t got,
			input reorder_info_t exp);
		if (got !== exp)
			stop_with_error($sformatf("FAIL t=%0t %s got %h exp %h", $time, name, got, exp));
	endtask

	task automatic check_class(input string name, input issue_class_e got, input issue_class_e exp);
		if (got !== exp)
			stop_with_error($sformatf("FAIL t=%0t %s got %s exp %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("FAIL t=%0t %s got %b exp %b", $time, name, got, exp));
	endtask

	// expected class, records and dispatch decision for a head under the given levels
	function automatic logic predict(input micro_op_t u, input logic [3:0] iq_full,
			input logic rob_full, input logic busy, output issue_class_e c,
			output issue_info_t ii, output reorder_info_t ri);
		logic           wr;
		logic           found;
		logic [`RB-1:0] fc;
		phys_reg_t      rdn;
		wr    = u.rd_used && (u.rd != 5'd0);
		found = 1'b0;
		fc    = '0;
		for (int i = 0; i < `RP; i++) begin
			if (!found && !used_m[u.rd][i]) begin
				found = 1'b1;
				fc    = `RB'(i);
			end
		end
		if (u.op inside {op_jal, op_jalr, op_beq, op_bne, op_blt}) c = cls_bru;
		else if (u.op inside {op_lw, op_ld, op_sw, op_sd}) c = cls_lsu;
		else if (u.op inside {op_csrrw, op_csrrs}) c = cls_csr;
		else c = cls_alu;
		rdn = '{arch: u.rd, copy: wr ? fc : act_m[u.rd]};
		ii  = '{op: u.op, pc: u.pc, imm: u.imm, rd: rdn,
			rs1: '{arch: u.rs1, copy: act_m[u.rs1]}, rs2: '{arch: u.rs2, copy: act_m[u.rs2]}};
		ri  = '{pc: u.pc, rd: rdn, rd_used: wr, is_branch: u.op inside {op_beq, op_bne, op_blt},
			is_store: u.op inside {op_sw, op_sd}, is_csr: c == cls_csr};
		if (rob_full || (wr && !found)) return 1'b0;
		if (u.op == op_fence) return !busy;
		return !iq_full[c];
	endfunction

	// outputs are stable at the falling edge, the model then steps to the next rising edge
	task automatic compare_cycle();
		logic          exp_go;
		logic          was_full;
		logic [3:0]    pushes;
		micro_op_t     h;
		issue_class_e  exp_cls;
		issue_class_e  got_cls;
		issue_info_t   exp_ii;
		issue_info_t   got_ii;
		reorder_info_t exp_ri;
		pushes   = {csr_push, lsu_push, bru_push, alu_push};
		was_full = (model_q.size() == `IFIFO_DEPTH);
		exp_go   = 1'b0;
		check_flag("uop_full", uop_full, was_full);
		if (model_q.size() > 0) begin
			h      = model_q[0];
			exp_go = predict(h, {csr_full, lsu_full, bru_full, alu_full}, reorder_full,
				lsu_busy, exp_cls, exp_ii, exp_ri);
		end
		check_flag("reorder_push", reorder_push, exp_go);
		if (!exp_go || h.op == op_fence) begin
			check_flag("issue push", |pushes, 1'b0);
		end else begin
			if (!$onehot(pushes)) stop_with_error("expected exactly one issue push");
			for (int i = 0; i < 4; i++) begin
				if (pushes[i]) got_cls = issue_class_e'(i[1:0]);
			end
			case (got_cls)
				cls_alu: got_ii = alu_info;
				cls_bru: got_ii = bru_info;
				cls_lsu: got_ii = lsu_info;
				default: got_ii = csr_info;
			endcase
			check_class("issue class", got_cls, exp_cls);
			check_issue("issue info", got_ii, exp_ii);
		end
		if (exp_go) begin
			check_reorder("reorder_info", reorder_info, exp_ri);
			void'(model_q.pop_front());
			if (exp_ri.rd_used) begin
				act_m[exp_ri.rd.arch]                  = exp_ri.rd.copy;
				used_m[exp_ri.rd.arch][exp_ri.rd.copy] = 1'b1;
			end
		end
		if (commit_valid) used_m[commit_name.arch][commit_name.copy] = 1'b0;
		if (uop_push && !was_full) model_q.push_back(uop_in);
	endtask

	initial begin
		for (int i = 0; i < `ARCH_REGS; i++) begin
			act_m[i]  = '0;
			used_m[i] = `RP'(1);
		end
		forever begin
			@(negedge clk);
			if (!reset) compare_cycle();
		end
	end

	function automatic micro_op_t uop(input opcode_e op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		return '{op: op, pc: '0, imm: '0, rd: rd, rs1: rs1, rs2: rs2, rs1_used: 1'b1,
			rs2_used: 1'b1, rd_used: !(op inside {op_beq, op_bne, op_blt, op_sw, op_sd, op_fence})};
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// pc and imm are filled in here so every micro-op carries its own pattern
	task automatic send(input micro_op_t u);
		int n;
		n = 0;
		while (uop_full) begin
			idle(1);
			n++;
			if (n > 200) stop_with_error("timeout: instruction queue stayed full");
		end
		u.pc     = pc_ctr;
		u.imm    = {~pc_ctr[31:0], pc_ctr[31:0]};
		pc_ctr   = pc_ctr + 64'd4;
		uop_in   = u;
		uop_push = 1'b1;
		idle(1);
		uop_push = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (model_q.size() != 0) begin
			idle(1);
			n++;
			if (n > 200) stop_with_error("timeout: queued micro-ops never dispatched");
		end
	endtask

	initial begin
		errors       = 0;
		pc_ctr       = 64'h8000_0000;
		reset        = 1'b1;
		uop_push     = 1'b0;
		uop_in       = '0;
		{alu_full, bru_full, lsu_full, csr_full} = '0;
		reorder_full = 1'b0;
		lsu_busy     = 1'b0;
		commit_valid = 1'b0;
		commit_name  = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag("push outputs", |{alu_push, bru_push, lsu_push, csr_push, reorder_push}, 1'b0);
		check_flag("uop_full", uop_full, 1'b0);

		// every opcode once, each writer on its own register
		for (int i = 0; i <= int'(op_fence); i++) begin
			send(uop(opcode_e'(5'(i)), 5'(i + 1), 5'(i + 2), 5'(i + 3)));
		end
		wait_drained();

		// x25 takes copies 1 to 3, the reader then sees copy 3
		repeat (3) send(uop(op_addi, 5'd25, 5'd0, 5'd0));
		send(uop(op_add, 5'd26, 5'd25, 5'd25));
		wait_drained();

		// no copy of x25 left until commit frees copy 2
		send(uop(op_addi, 5'd25, 5'd1, 5'd0));
		idle(4);
		check_flag("writer stalled", reorder_push, 1'b0);
		commit_name  = '{arch: 5'd25, copy: 2'd2};
		commit_valid = 1'b1;
		idle(1);
		commit_valid = 1'b0;
		wait_drained();

		// full alu, bru and lsu queues hold the head and all behind it
		alu_full = 1'b1;
		bru_full = 1'b1;
		lsu_full = 1'b1;
		fork
			begin
				send(uop(op_add, 5'd0, 5'd3, 5'd4));
				send(uop(op_beq, 5'd0, 5'd3, 5'd4));
				send(uop(op_lw, 5'd0, 5'd5, 5'd0));
				send(uop(op_and, 5'd0, 5'd6, 5'd7));
				send(uop(op_sd, 5'd0, 5'd8, 5'd9));
			end
			begin
				idle(8);
				alu_full = 1'b0;
				idle(2);
				bru_full = 1'b0;
				idle(2);
				lsu_full = 1'b0;
			end
		join
		wait_drained();

		// a full reorder queue and then a full csr queue hold the csr op
		reorder_full = 1'b1;
		csr_full     = 1'b1;
		send(uop(op_csrrw, 5'd0, 5'd10, 5'd0));
		send(uop(op_jal, 5'd0, 5'd0, 5'd0));
		idle(4);
		reorder_full = 1'b0;
		idle(2);
		csr_full = 1'b0;
		wait_drained();

		// fence waits for the load/store side
		lsu_busy = 1'b1;
		send(uop(op_fence, 5'd0, 5'd0, 5'd0));
		send(uop(op_or, 5'd0, 5'd11, 5'd12));
		idle(4);
		lsu_busy = 1'b0;
		wait_drained();
		idle(2);

		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verification/dispatch_assertions.sv
// concurrent checks on the dispatch top, attached with bind
// one issue push at a time, reorder push follows dispatch, no push into a full queue

`timescale 1ns/10ps

module dispatch_assertions import dispatch_pkg::*; (
	input logic      CLK,
	input logic      reset,
	input logic      alu_push,
	input logic      bru_push,
	input logic      lsu_push,
	input logic      csr_push,
	input logic      alu_full,
	input logic      bru_full,
	input logic      lsu_full,
	input logic      csr_full,
	input logic      reorder_push,
	input logic      reorder_full,
	input logic      fifo_pop,
	input micro_op_t fifo_head
);

	logic [3:0] pushes;

	assign pushes = {csr_push, lsu_push, bru_push, alu_push};

	a_one_push: assert property (@(posedge CLK) disable iff (reset) $onehot0(pushes))
		else $error("more than one issue push in a cycle");

	// a fence leaves with a reorder record only
	a_reorder_push: assert property (@(posedge CLK) disable iff (reset)
		reorder_push == ((|pushes) | (fifo_pop & (fifo_head.op == op_fence))))
		else $error("reorder push does not match the dispatch");

	a_no_full_push: assert property (@(posedge CLK) disable iff (reset)
		!(alu_push & alu_full) && !(bru_push & bru_full) && !(lsu_push & lsu_full) &&
		!(csr_push & csr_full) && !(reorder_push & reorder_full))
		else $error("push into a full queue");

endmodule

bind dispatch_top dispatch_assertions u_checks (
	.CLK(CLK), .reset(reset),
	.alu_push(alu_push), .bru_push(bru_push), .lsu_push(lsu_push), .csr_push(csr_push),
	.alu_full(alu_full), .bru_full(bru_full), .lsu_full(lsu_full), .csr_full(csr_full),
	.reorder_push(reorder_push), .reorder_full(reorder_full),
	.fifo_pop(fifo_pop), .fifo_head(fifo_head)
);

//--- verilog/dispatch_top.sv
// dispatch stage top: instruction queue, dispatch and rename tables
// issue queues, reorder buffer and commit sit outside on plain ports

`timescale 1ns/10ps

module dispatch_top import dispatch_pkg::*; (
	input  logic          CLK,
	input  logic          reset,

	input  logic          uop_push,
	input  micro_op_t     uop_in,
	output logic          uop_full,

	output logic          alu_push,
	input  logic          alu_full,
	output issue_info_t   alu_info,
	output logic          bru_push,
	input  logic          bru_full,
	output issue_info_t   bru_info,
	output logic          lsu_push,
	input  logic          lsu_full,
	output issue_info_t   lsu_info,
	output logic          csr_push,
	input  logic          csr_full,
	output issue_info_t   csr_info,

	output logic          reorder_push,
	input  logic          reorder_full,
	output reorder_info_t reorder_info,

	input  logic          lsu_busy,
	input  logic          commit_valid,
	input  phys_reg_t     commit_name
);

	micro_op_t fifo_head;
	logic      fifo_empty;
	logic      fifo_pop;

	rename_if rn ();

	instr_fifo i_instr_fifo (
		.CLK    (CLK),
		.reset  (reset),
		.push   (uop_push),
		.data_in(uop_in),
		.pop    (fifo_pop),
		.head   (fifo_head),
		.empty  (fifo_empty),
		.full   (uop_full)
	);

	dispatch i_dispatch (
		.head(fifo_head), .empty(fifo_empty), .pop(fifo_pop),
		.alu_push(alu_push), .alu_full(alu_full), .alu_info(alu_info),
		.bru_push(bru_push), .bru_full(bru_full), .bru_info(bru_info),
		.lsu_push(lsu_push), .lsu_full(lsu_full), .lsu_info(lsu_info),
		.csr_push(csr_push), .csr_full(csr_full), .csr_info(csr_info),
		.reorder_push(reorder_push), .reorder_full(reorder_full),
		.reorder_info(reorder_info),
		.lsu_busy(lsu_busy),
		.rn(rn.user)
	);

	rename_state i_rename_state (
		.CLK         (CLK),
		.reset       (reset),
		.rn          (rn.state),
		.commit_valid(commit_valid),
		.commit_name (commit_name)
	);

endmodule

//--- verilog/dispatch.sv
// dispatch stage: issue-class steering, stall logic and reorder record
// renames the queue head and pops it in the cycle it leaves

`timescale 1ns/10ps

module dispatch import dispatch_pkg::*; (
	input  micro_op_t     head,
	input  logic          empty,
	output logic          pop,

	output logic          alu_push,
	input  logic          alu_full,
	output issue_info_t   alu_info,

	output logic          bru_push,
	input  logic          bru_full,
	output issue_info_t   bru_info,

	output logic          lsu_push,
	input  logic          lsu_full,
	output issue_info_t   lsu_info,

	output logic          csr_push,
	input  logic          csr_full,
	output issue_info_t   csr_info,

	output logic          reorder_push,
	input  logic          reorder_full,
	output reorder_info_t reorder_info,

	input  logic          lsu_busy,
	rename_if.user        rn
);

	issue_class_e cls;
	logic         is_fence;
	logic         rd_valid;
	logic         run_out;
	logic         target_ok;
	logic         go;
	phys_reg_t    rs1_name;
	phys_reg_t    rs2_name;
	phys_reg_t    rd_name;
	issue_info_t  info;

	function automatic issue_class_e class_of(opcode_e op);
		case (op)
			op_jal, op_jalr, op_beq, op_bne, op_blt: class_of = cls_bru;
			op_lw, op_ld, op_sw, op_sd:              class_of = cls_lsu;
			op_csrrw, op_csrrs:                      class_of = cls_csr;
			default:                                 class_of = cls_alu;
		endcase
	endfunction

	assign cls      = class_of(head.op);
	assign is_fence = (head.op == op_fence);

	// x0 is never renamed
	assign rd_valid = head.rd_used & (head.rd != '0);

	rename i_rename (
		.rn      (rn),
		.rs1     (head.rs1),
		.rs2     (head.rs2),
		.rd      (head.rd),
		.rd_valid(rd_valid),
		.alloc   (go),
		.rs1_name(rs1_name),
		.rs2_name(rs2_name),
		.rd_name (rd_name),
		.run_out (run_out)
	);

	// fence has no issue queue, it waits for the load/store side to drain
	always_comb begin
		if (is_fence) begin
			target_ok = ~lsu_busy;
		end else begin
			case (cls)
				cls_alu: target_ok = ~alu_full;
				cls_bru: target_ok = ~bru_full;
				cls_lsu: target_ok = ~lsu_full;
				default: target_ok = ~csr_full;
			endcase
		end
	end

	assign go = ~empty & ~reorder_full & ~run_out & target_ok;

	assign alu_push     = go & ~is_fence & (cls == cls_alu);
	assign bru_push     = go & ~is_fence & (cls == cls_bru);
	assign lsu_push     = go & ~is_fence & (cls == cls_lsu);
	assign csr_push     = go & ~is_fence & (cls == cls_csr);
	assign reorder_push = go;
	assign pop          = go;

	assign info = '{op: head.op, pc: head.pc, imm: head.imm,
			rd: rd_name, rs1: rs1_name, rs2: rs2_name};

	assign alu_info = info;
	assign bru_info = info;
	assign lsu_info = info;
	assign csr_info = info;

	// rd_used in the record means a real copy was taken, so commit can free it
	assign reorder_info = '{
		pc:        head.pc,
		rd:        rd_name,
		rd_used:   rd_valid,
		is_branch: (head.op == op_beq) | (head.op == op_bne) | (head.op == op_blt),
		is_store:  (head.op == op_sw) | (head.op == op_sd),
		is_csr:    (cls == cls_csr)
	};

endmodule

//--- verilog/instr_fifo.sv
// show-ahead queue of decoded micro-ops
// head entry is readable while the queue is not empty

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module instr_fifo import dispatch_pkg::*; (
	input  logic      CLK,
	input  logic      reset,
	input  logic      push,
	input  micro_op_t data_in,
	input  logic      pop,
	output micro_op_t head,
	output logic      empty,
	output logic      full
);

	localparam int aw = $clog2(`IFIFO_DEPTH);

	micro_op_t mem [`IFIFO_DEPTH];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0]   count;
	logic          do_push;
	logic          do_pop;

	assign empty   = (count == '0);
	assign full    = (count == (aw+1)'(`IFIFO_DEPTH));
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + (aw+1)'(do_push) - (aw+1)'(do_pop);
		end
	end

endmodule

//--- verilog/rename.sv
// combinational register renaming
// sources read the active copy, destination takes the lowest free copy

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module rename import dispatch_pkg::*; (
	rename_if.user             rn,
	input  logic [`ARCH_AW-1:0] rs1,
	input  logic [`ARCH_AW-1:0] rs2,
	input  logic [`ARCH_AW-1:0] rd,
	input  logic                rd_valid,
	input  logic                alloc,
	output phys_reg_t           rs1_name,
	output phys_reg_t           rs2_name,
	output phys_reg_t           rd_name,
	output logic                run_out
);

	logic [`RP-1:0] rd_used_bits;
	logic [`RB-1:0] free_copy;

	assign rd_used_bits = rn.bufu_qout[rd];

	// scan downwards so the lowest free copy wins
	always_comb begin
		free_copy = '0;
		for (int i = `RP - 1; i >= 0; i--) begin
			if (!rd_used_bits[i]) begin
				free_copy = i[`RB-1:0];
			end
		end
	end

	assign run_out = rd_valid & (&rd_used_bits);

	assign rs1_name = '{arch: rs1, copy: rn.act_qout[rs1]};
	assign rs2_name = '{arch: rs2, copy: rn.act_qout[rs2]};
	assign rd_name  = '{arch: rd, copy: rd_valid ? free_copy : rn.act_qout[rd]};

	// state moves only when the instruction actually leaves
	always_comb begin
		rn.act_dnxt = rn.act_qout;
		rn.bufu_set = '0;
		if (alloc && rd_valid && !run_out) begin
			rn.act_dnxt[rd]            = free_copy;
			rn.bufu_set[rd][free_copy] = 1'b1;
		end
	end

endmodule

//--- verilog/rename_state.sv
// rename tables: active copy pointer and used bits per architectural register
// set by dispatch through the rename bus, cleared by commit

`timescale 1ns/10ps
`include "dispatch_consts.svh"

module rename_state import dispatch_pkg::*; (
	input  logic      CLK,
	input  logic      reset,
	rename_if.state   rn,
	input  logic      commit_valid,
	input  phys_reg_t commit_name
);

	logic [`ARCH_REGS-1:0][`RB-1:0] act_q;
	logic [`ARCH_REGS-1:0][`RP-1:0] bufu_q;
	logic [`ARCH_REGS-1:0][`RP-1:0] bufu_clr;

	assign rn.act_qout  = act_q;
	assign rn.bufu_qout = bufu_q;

	// one-hot release of the committed copy
	always_comb begin
		bufu_clr = '0;
		if (commit_valid) begin
			bufu_clr[commit_name.arch][commit_name.copy] = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			act_q  <= '0;
			// copy 0 of every register holds the architectural value
			bufu_q <= {`ARCH_REGS{`RP'(1)}};
		end else begin
			act_q  <= rn.act_dnxt;
			bufu_q <= (bufu_q | rn.bufu_set) & ~bufu_clr;
		end
	end

endmodule

//--- verilog/rename_if.sv
// rename bus between the rename state registers and the renamer
// state side owns the tables, user side returns next pointers and new used bits

`timescale 1ns/10ps
`include "dispatch_consts.svh"

interface rename_if;

	logic [`ARCH_REGS-1:0][`RB-1:0] act_qout;
	logic [`ARCH_REGS-1:0][`RP-1:0] bufu_qout;
	logic [`ARCH_REGS-1:0][`RB-1:0] act_dnxt;
	logic [`ARCH_REGS-1:0][`RP-1:0] bufu_set;

	modport state (output act_qout, output bufu_qout, input act_dnxt, input bufu_set);

	modport user (input act_qout, input bufu_qout, output act_dnxt, output bufu_set);

endinterface

//--- verilog/dispatch_pkg.sv
// opcode and issue-class enums
// micro-op, physical register name and issue/reorder record structs

`include "dispatch_consts.svh"

package dispatch_pkg;

	// supported operations after decode
	typedef enum logic [4:0] {
		op_add,
		op_addi,
		op_sub,
		op_lui,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_sll,
		op_srl,
		op_sra,
		op_jal,
		op_jalr,
		op_beq,
		op_bne,
		op_blt,
		op_lw,
		op_ld,
		op_sw,
		op_sd,
		op_csrrw,
		op_csrrs,
		op_fence
	} opcode_e;

	// merged issue queues
	typedef enum logic [1:0] {
		cls_alu,
		cls_bru,
		cls_lsu,
		cls_csr
	} issue_class_e;

	// architectural index paired with a copy index
	typedef struct packed {
		logic [`ARCH_AW-1:0] arch;
		logic [`RB-1:0]      copy;
	} phys_reg_t;

	typedef struct packed {
		opcode_e             op;
		logic [63:0]         pc;
		logic [63:0]         imm;
		logic [`ARCH_AW-1:0] rd;
		logic [`ARCH_AW-1:0] rs1;
		logic [`ARCH_AW-1:0] rs2;
		logic                rd_used;
		logic                rs1_used;
		logic                rs2_used;
	} micro_op_t;

	typedef struct packed {
		opcode_e     op;
		logic [63:0] pc;
		logic [63:0] imm;
		phys_reg_t   rd;
		phys_reg_t   rs1;
		phys_reg_t   rs2;
	} issue_info_t;

	typedef struct packed {
		logic [63:0] pc;
		phys_reg_t   rd;
		logic        rd_used;
		logic        is_branch;
		logic        is_store;
		logic        is_csr;
	} reorder_info_t;

endpackage

//--- verilog/dispatch_consts.svh
// register counts, rename widths and instruction queue depth
// shared by the package, the rename interface and the RTL modules

`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// width of a copy index
`define RB 2

// copies per architectural register, 2**RB
`define RP 4

// architectural integer registers
`define ARCH_REGS 32

// width of an architectural register index
`define ARCH_AW 5

// entries in the show-ahead instruction queue
`define IFIFO_DEPTH 4

`endif
